//--- Bender.yml
package:
  name: logic_analyzer

sources:
  - files:
      - design/la_pkg.sv
      - design/rstn_sync.sv
      - design/channel_trigger.sv
      - design/trigger_unit.sv
      - design/wave_store.sv
      - design/axi_reg_slave.sv
      - design/logic_analyzer_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_logic_analyzer.sv

//--- design/axi_reg_slave.sv
`timescale 1ns/100ps

module axi_reg_slave import la_pkg::*; #(
    parameter int chan_num        = 8,
    parameter int wave_addr_width = 12
) (
    input  logic                       clk,
    input  logic                       analyzer_rstn_sync,
    input  logic [bus_id_w-1:0]        aw_id,
    input  logic [31:0]                aw_addr,
    input  logic [7:0]                 aw_len,    // write bursts end on w_last
    input  logic [1:0]                 aw_burst,
    input  logic                       aw_valid,
    output logic                       aw_ready,
    input  logic [31:0]                w_data,
    input  logic [3:0]                 w_strb,
    input  logic                       w_last,
    input  logic                       w_valid,
    output logic                       w_ready,
    output logic [bus_id_w-1:0]        b_id,
    output logic [1:0]                 b_resp,
    output logic                       b_valid,
    input  logic                       b_ready,
    input  logic [bus_id_w-1:0]        ar_id,
    input  logic [31:0]                ar_addr,
    input  logic [7:0]                 ar_len,
    input  logic [1:0]                 ar_burst,
    input  logic                       ar_valid,
    output logic                       ar_ready,
    output logic [bus_id_w-1:0]        r_id,
    output logic [31:0]                r_data,
    output logic [1:0]                 r_resp,
    output logic                       r_last,
    output logic                       r_valid,
    input  logic                       r_ready,
    output logic                       arm,
    output logic                       force_trig,
    output global_mode_e               mode,
    output chan_cfg_t [chan_num-1:0]   chan_cfg,
    output logic                       rearm,
    input  logic                       beat_hit,
    input  logic                       busy,
    input  logic                       done,
    output logic [wave_addr_width-1:0] wave_rd_addr,
    input  logic [31:0]                wave_word
);

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;
    typedef enum logic {RD_IDLE, RD_DATA} rd_state_e;

    wr_state_e           wr_state;
    rd_state_e           rd_state;
    logic [bus_id_w-1:0] wr_id, rd_id;
    logic [31:0]         wr_addr, rd_addr;
    axi_burst_e          wr_burst, rd_burst;
    logic [7:0]          rd_len, rd_cnt;
    logic                wr_err, w_err_now, reg_wr;
    logic                aw_fire, w_fire, b_fire, ar_fire, r_fire;
    logic                addr_chg, r_hold, rd_wave;
    logic [31:0]         rd_mux, r_held;

    assign aw_fire   = aw_valid && aw_ready;
    assign w_fire    = w_valid && w_ready;
    assign b_fire    = b_valid && b_ready;
    assign w_ready   = (wr_state == WR_DATA);
    assign b_valid   = (wr_state == WR_RESP);
    assign b_id      = wr_id;
    assign b_resp    = wr_err ? RESP_SLVERR : RESP_OKAY;
    assign w_err_now = (wr_burst == BURST_WRAP) || (wr_burst == BURST_RSVD)
                       || (wr_addr[31:24] == WAVE_BASE[31:24]);   // wave memory is read only
    assign reg_wr    = w_fire && !w_err_now;
    assign rearm     = reg_wr && (wr_addr == REG_CTRL) && w_strb[0] && w_data[CTRL_ON_BIT];

    // write channel FSM
    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            wr_state <= WR_IDLE;
            aw_ready <= 1'b0;
            wr_err   <= 1'b0;
        end else begin
            case (wr_state)
                WR_IDLE: if (aw_fire) wr_state <= WR_DATA;
                WR_DATA: if (w_fire && w_last) wr_state <= WR_RESP;
                default: if (b_fire) wr_state <= WR_IDLE;
            endcase
            aw_ready <= (wr_state == WR_IDLE && !aw_fire) || b_fire;
            if (aw_fire) begin
                wr_err <= 1'b0;
            end else if (w_fire && w_err_now) begin
                wr_err <= 1'b1;   // sticky until next burst
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_id    <= aw_id;
            wr_addr  <= aw_addr;
            wr_burst <= axi_burst_e'(aw_burst);
        end else if (w_fire && wr_burst == BURST_INCR) begin
            wr_addr <= wr_addr + 32'd1;
        end
    end

    // control registers, strobe 0 for low fields and strobe 1 for force
    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            arm        <= 1'b0;
            force_trig <= 1'b0;
            mode       <= GLOBAL_AND;
            chan_cfg   <= {chan_num{chan_cfg_rst}};
        end else begin
            force_trig <= 1'b0;   // single cycle pulse
            if (beat_hit) begin
                arm <= 1'b0;
            end
            if (reg_wr && w_strb[0]) begin
                if (wr_addr == REG_CTRL) arm <= w_data[CTRL_ON_BIT];
                if (wr_addr == REG_MODE) mode <= global_mode_e'(w_data[1:0]);
                for (int i = 0; i < chan_num; i++) begin
                    if (wr_addr == REG_CHAN_BASE + 32'(i)) chan_cfg[i] <= chan_cfg_t'(w_data[5:0]);
                end
            end
            if (reg_wr && w_strb[1] && wr_addr == REG_CTRL) begin
                force_trig <= w_data[CTRL_FORCE_BIT];
            end
        end
    end

    assign ar_fire      = ar_valid && ar_ready;
    assign r_fire       = r_valid && r_ready;
    assign rd_wave      = (rd_addr[31:24] == WAVE_BASE[31:24]);
    assign r_valid      = (rd_state == RD_DATA) && !(rd_wave && addr_chg);   // memory needs a cycle
    assign r_last       = (rd_state == RD_DATA) && (rd_cnt == rd_len);
    assign r_resp       = (rd_burst == BURST_WRAP || rd_burst == BURST_RSVD) ? RESP_SLVERR : RESP_OKAY;
    assign r_id         = rd_id;
    assign r_data       = r_hold ? r_held : rd_mux;
    assign wave_rd_addr = rd_addr[wave_addr_width-1:0];

    // read channel FSM
    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            rd_state <= RD_IDLE;
            ar_ready <= 1'b0;
            addr_chg <= 1'b0;
            r_hold   <= 1'b0;
        end else begin
            case (rd_state)
                RD_IDLE: if (ar_fire) rd_state <= RD_DATA;
                default: if (r_fire && r_last) rd_state <= RD_IDLE;
            endcase
            ar_ready <= (rd_state == RD_IDLE && !ar_fire) || (r_fire && r_last);
            addr_chg <= ar_fire || (r_fire && rd_burst == BURST_INCR);
            r_hold   <= r_valid && !r_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_id    <= ar_id;
            rd_addr  <= ar_addr;
            rd_len   <= ar_len;
            rd_burst <= axi_burst_e'(ar_burst);
            rd_cnt   <= '0;
        end else if (r_fire) begin
            rd_cnt <= rd_cnt + 8'd1;
            if (rd_burst == BURST_INCR) rd_addr <= rd_addr + 32'd1;   // FIXED rereads
        end
        if (r_valid && !r_hold) begin
            r_held <= rd_mux;   // frozen while the master stalls
        end
    end

    always_comb begin
        rd_mux = '1;   // unmapped
        if (rd_wave) begin
            rd_mux = wave_word;
        end else if (rd_addr == REG_CTRL) begin
            rd_mux                 = '0;
            rd_mux[CTRL_ON_BIT]    = arm;
            rd_mux[CTRL_FORCE_BIT] = force_trig;
            rd_mux[CTRL_BUSY_BIT]  = busy;
            rd_mux[CTRL_DONE_BIT]  = done;
        end else if (rd_addr == REG_MODE) begin
            rd_mux = 32'(mode);
        end else begin
            for (int i = 0; i < chan_num; i++) begin
                if (rd_addr == REG_CHAN_BASE + 32'(i)) rd_mux = 32'(chan_cfg[i]);
            end
        end
    end

endmodule

//--- design/channel_trigger.sv
`timescale 1ns/100ps

module channel_trigger import la_pkg::*; (
    input  logic      clk,
    input  logic      analyzer_rstn_sync,
    input  logic      din,
    input  chan_cfg_t cfg,
    output logic      match
);

    logic prev;   // sample of the previous cycle
    logic raw;

    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            prev <= 1'b0;
        end else begin
            prev <= din;
        end
    end

    // condition value against the current level and last sample
    always_comb begin
        case (cfg.value)
            LOGIC0:    raw = ~din;
            LOGIC1:    raw = din;
            RISE:      raw = din & ~prev;
            FALL:      raw = ~din & prev;
            ANY_EDGE:  raw = din ^ prev;
            NO_CHANGE: raw = din ~^ prev;
            default:   raw = 1'b1;   // DONT_CARE, SOME_NUMBER
        endcase
    end

    // ordering operators fall back to plain equality
    assign match = (cfg.op == OP_NE) ? ~raw : raw;

endmodule

//--- design/la_pkg.sv
package la_pkg;

    localparam int bus_id_w = 4;   // fixed id width of the slave bus
    localparam int sample_w = 8;   // one sample byte, four to a memory word

    // per-channel condition value
    typedef enum logic [2:0] {
        LOGIC0,
        LOGIC1,
        DONT_CARE,
        RISE,
        FALL,
        ANY_EDGE,
        NO_CHANGE,
        SOME_NUMBER      // treated as don't care
    } trig_val_e;

    // comparison operator, only OP_NE differs from OP_EQ
    typedef enum logic [2:0] {
        OP_EQ,
        OP_NE,
        OP_LT,
        OP_LE,
        OP_GT,
        OP_GE
    } trig_op_e;

    typedef struct packed {
        trig_val_e value;   // bits 5:3
        trig_op_e  op;      // bits 2:0
    } chan_cfg_t;

    localparam chan_cfg_t chan_cfg_rst = '{value: DONT_CARE, op: OP_EQ};   // reads 0x10

    typedef enum logic [1:0] {GLOBAL_AND, GLOBAL_OR, GLOBAL_NAND, GLOBAL_NOR} global_mode_e;

    typedef enum logic [1:0] {RESP_OKAY = 2'd0, RESP_SLVERR = 2'd2} axi_resp_e;

    typedef enum logic [1:0] {BURST_FIXED, BURST_INCR, BURST_WRAP, BURST_RSVD} axi_burst_e;

    // trigger stage to storage stage
    typedef struct packed {
        logic [sample_w-1:0] sample;
        logic                hit;
    } trig_beat_t;

    // register map, word addresses
    localparam logic [31:0] REG_CTRL      = 32'h0000_0000;
    localparam logic [31:0] REG_MODE      = 32'h0000_0001;
    localparam logic [31:0] REG_CHAN_BASE = 32'h0000_0010;
    localparam logic [31:0] WAVE_BASE     = 32'h0100_0000;   // whole 0x01xx_xxxx region

    localparam int CTRL_ON_BIT    = 0;
    localparam int CTRL_FORCE_BIT = 8;
    localparam int CTRL_BUSY_BIT  = 16;
    localparam int CTRL_DONE_BIT  = 24;

endpackage

//--- design/logic_analyzer_top.sv
`timescale 1ns/100ps

module logic_analyzer_top import la_pkg::*; #(
    parameter int chan_num        = 8,
    parameter int wave_addr_width = 12   // 1024 words, 4096 samples
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic [chan_num-1:0] digital_in,
    input  logic [bus_id_w-1:0] aw_id,
    input  logic [31:0]         aw_addr,
    input  logic [7:0]          aw_len,
    input  logic [1:0]          aw_burst,
    input  logic                aw_valid,
    output logic                aw_ready,
    input  logic [31:0]         w_data,
    input  logic [3:0]          w_strb,
    input  logic                w_last,
    input  logic                w_valid,
    output logic                w_ready,
    output logic [bus_id_w-1:0] b_id,
    output logic [1:0]          b_resp,
    output logic                b_valid,
    input  logic                b_ready,
    input  logic [bus_id_w-1:0] ar_id,
    input  logic [31:0]         ar_addr,
    input  logic [7:0]          ar_len,
    input  logic [1:0]          ar_burst,
    input  logic                ar_valid,
    output logic                ar_ready,
    output logic [bus_id_w-1:0] r_id,
    output logic [31:0]         r_data,
    output logic [1:0]          r_resp,
    output logic                r_last,
    output logic                r_valid,
    input  logic                r_ready
);

    logic                       analyzer_rstn_sync;
    logic                       arm, force_trig, rearm, busy, done;
    global_mode_e               mode;
    chan_cfg_t [chan_num-1:0]   chan_cfg;
    trig_beat_t                 beat;
    logic [wave_addr_width-1:0] wave_rd_addr;
    logic [31:0]                wave_word;

    rstn_sync u_rstn_sync (
        .clk       (clk),
        .rstn      (rstn),
        .rstn_sync (analyzer_rstn_sync)
    );

    trigger_unit #(.chan_num(chan_num)) u_trigger (
        .clk                (clk),
        .analyzer_rstn_sync (analyzer_rstn_sync),
        .digital_in         (digital_in),
        .arm                (arm),
        .force_trig         (force_trig),
        .mode               (mode),
        .chan_cfg           (chan_cfg),
        .beat               (beat)
    );

    wave_store #(.chan_num(chan_num), .wave_addr_width(wave_addr_width)) u_store (
        .clk                (clk),
        .analyzer_rstn_sync (analyzer_rstn_sync),
        .beat               (beat),
        .rearm              (rearm),
        .wave_rd_addr       (wave_rd_addr),
        .busy               (busy),
        .done               (done),
        .wave_word          (wave_word)
    );

    axi_reg_slave #(.chan_num(chan_num), .wave_addr_width(wave_addr_width)) u_slave (
        .clk                (clk),
        .analyzer_rstn_sync (analyzer_rstn_sync),
        .aw_id              (aw_id),
        .aw_addr            (aw_addr),
        .aw_len             (aw_len),
        .aw_burst           (aw_burst),
        .aw_valid           (aw_valid),
        .aw_ready           (aw_ready),
        .w_data             (w_data),
        .w_strb             (w_strb),
        .w_last             (w_last),
        .w_valid            (w_valid),
        .w_ready            (w_ready),
        .b_id               (b_id),
        .b_resp             (b_resp),
        .b_valid            (b_valid),
        .b_ready            (b_ready),
        .ar_id              (ar_id),
        .ar_addr            (ar_addr),
        .ar_len             (ar_len),
        .ar_burst           (ar_burst),
        .ar_valid           (ar_valid),
        .ar_ready           (ar_ready),
        .r_id               (r_id),
        .r_data             (r_data),
        .r_resp             (r_resp),
        .r_last             (r_last),
        .r_valid            (r_valid),
        .r_ready            (r_ready),
        .arm                (arm),
        .force_trig         (force_trig),
        .mode               (mode),
        .chan_cfg           (chan_cfg),
        .rearm              (rearm),
        .beat_hit           (beat.hit),   // clears arm
        .busy               (busy),
        .done               (done),
        .wave_rd_addr       (wave_rd_addr),
        .wave_word          (wave_word)
    );

endmodule

//--- design/rstn_sync.sv
`timescale 1ns/100ps

module rstn_sync (
    input  logic clk,
    input  logic rstn,
    output logic rstn_sync
);

    logic meta;

    // asserts at once, releases two edges later
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            meta      <= 1'b0;
            rstn_sync <= 1'b0;
        end else begin
            meta      <= 1'b1;
            rstn_sync <= meta;
        end
    end

endmodule

//--- design/trigger_unit.sv
`timescale 1ns/100ps

module trigger_unit import la_pkg::*; #(
    parameter int chan_num = 8
) (
    input  logic                     clk,
    input  logic                     analyzer_rstn_sync,
    input  logic [chan_num-1:0]      digital_in,
    input  logic                     arm,
    input  logic                     force_trig,
    input  global_mode_e             mode,
    input  chan_cfg_t [chan_num-1:0] chan_cfg,
    output trig_beat_t               beat
);

    logic [chan_num-1:0] chan_match;
    logic                comb_hit;

    for (genvar i = 0; i < chan_num; i++) begin : g_chan
        channel_trigger u_chan (
            .clk                (clk),
            .analyzer_rstn_sync (analyzer_rstn_sync),
            .din                (digital_in[i]),
            .cfg                (chan_cfg[i]),
            .match              (chan_match[i])
        );
    end

    // global combine of the per-channel matches
    always_comb begin
        case (mode)
            GLOBAL_AND:  comb_hit = &chan_match;
            GLOBAL_OR:   comb_hit = |chan_match;
            GLOBAL_NAND: comb_hit = ~(&chan_match);
            default:     comb_hit = ~(|chan_match);
        endcase
    end

    // sample k leaves here in cycle k+1 with its own hit
    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            beat <= '0;
        end else begin
            beat.sample <= sample_w'(digital_in);
            beat.hit    <= (arm & comb_hit) | force_trig;   // force needs no arm
        end
    end

endmodule

//--- design/wave_store.sv
`timescale 1ns/100ps

module wave_store import la_pkg::*; #(
    parameter int chan_num        = 8,
    parameter int wave_addr_width = 12
) (
    input  logic                       clk,
    input  logic                       analyzer_rstn_sync,
    input  trig_beat_t                 beat,
    input  logic                       rearm,
    input  logic [wave_addr_width-1:0] wave_rd_addr,
    output logic                       busy,
    output logic                       done,
    output logic [31:0]                wave_word
);

    typedef enum logic [1:0] {IDLE, CAPTURE, FULL} cap_state_e;

    localparam int cnt_w   = wave_addr_width;       // sample index
    localparam int word_aw = wave_addr_width - 2;   // four samples per word

    cap_state_e          state;
    logic [cnt_w-1:0]    cnt;
    logic [23:0]         pack;   // first three samples of the word
    logic [sample_w-1:0] smp;
    logic                take;
    logic [31:0]         mem [2**word_aw];

    assign smp  = sample_w'(beat.sample[chan_num-1:0]);
    assign take = (state == CAPTURE) || (state == IDLE && beat.hit);   // hit beat is sample 0
    assign busy = take;
    assign done = (state == FULL);

    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (beat.hit) begin
                        state <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    if (&cnt) begin
                        state <= FULL;   // last word goes in this edge
                    end
                end
                default: begin
                    if (rearm) begin
                        state <= IDLE;
                    end
                end
            endcase
            if (take) begin
                cnt <= cnt + 1'b1;   // wraps to zero at the end
            end
        end
    end

    // low byte holds the oldest sample
    always_ff @(posedge clk) begin
        if (take) begin
            case (cnt[1:0])
                2'd0:    pack[7:0]   <= smp;
                2'd1:    pack[15:8]  <= smp;
                2'd2:    pack[23:16] <= smp;
                default: mem[cnt[cnt_w-1:2]] <= {smp, pack};
            endcase
        end
        wave_word <= mem[wave_rd_addr[word_aw-1:0]];   // one cycle read latency
    end

endmodule

//--- sim.f
+incdir+testbench
design/la_pkg.sv
design/rstn_sync.sv
design/channel_trigger.sv
design/trigger_unit.sv
design/wave_store.sv
design/axi_reg_slave.sv
design/logic_analyzer_top.sv
testbench/tb_logic_analyzer.sv

//--- testbench/la_tb_tasks.svh
// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per output bit
function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_next(lfsr);
        v    = {v[6:0], lfsr[0]};
    end
    return v;
endfunction

task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

// burst write of wr_buf[0..n-1], length set by w_last
task automatic bus_write(input logic [31:0] addr, input logic [1:0] burst, input int n,
                         input logic [3:0] strb, output logic [1:0] resp);
    logic [bus_id_w-1:0] id;
    bit                  hs;
    id       = next_id;
    next_id  = next_id + 1'b1;
    aw_id    = id;
    aw_addr  = addr;
    aw_len   = 8'(n - 1);
    aw_burst = burst;
    aw_valid = 1'b1;
    do begin
        hs = aw_ready;   // stable until the next edge
        next_cycle();
    end while (!hs);
    aw_valid = 1'b0;
    for (int i = 0; i < n; i++) begin
        w_data  = wr_buf[i];
        w_strb  = strb;
        w_last  = (i == n - 1);
        w_valid = 1'b1;
        do begin
            hs = w_ready;
            next_cycle();
        end while (!hs);
    end
    w_valid = 1'b0;
    w_last  = 1'b0;
    wr_idx  = cyc;   // first sample that sees the new register values
    b_ready = 1'b1;
    do begin
        hs   = b_valid;
        resp = b_resp;
        assert (!hs || b_id == id) else value_error("b_id", 32'(id), 32'(b_id));
        next_cycle();
    end while (!hs);
    b_ready = 1'b0;
endtask

// beats are checked by the compare process
task automatic bus_read(input logic [31:0] addr, input int len, input logic [1:0] burst,
                        input bit chk, input bit stall);
    bit hs;
    cur.id   = next_id;
    next_id  = next_id + 1'b1;
    cur.len  = 8'(len);
    cur.resp = (burst == BURST_WRAP || burst == BURST_RSVD) ? RESP_SLVERR : RESP_OKAY;
    cur.chk  = chk;
    rd_beat  = 0;
    rd_done  = 1'b0;
    ar_id    = cur.id;
    ar_addr  = addr;
    ar_len   = 8'(len);
    ar_burst = burst;
    ar_valid = 1'b1;
    do begin
        hs = ar_ready;
        next_cycle();
    end while (!hs);
    ar_valid = 1'b0;
    while (!rd_done) begin
        r_ready = stall ? (rand_bits(1) != 8'd0) : 1'b1;
        next_cycle();
    end
    r_ready = 1'b0;
    assert (rd_beat == len + 1) else value_error("beat count", 32'(len + 1), 32'(rd_beat));
    assert (exp_data.size() == 0) else abort_run("read burst ended with words still expected");
endtask

task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    wr_buf[0] = data;
    bus_write(addr, BURST_INCR, 1, 4'hf, resp);
    assert (resp == RESP_OKAY) else value_error("b_resp", 32'(RESP_OKAY), 32'(resp));
endtask

task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp);
    exp_data.push_back(exp);
    bus_read(addr, 0, BURST_INCR, 1'b1, 1'b0);
endtask

// expected match of one channel, from the trigger rules
function automatic bit chan_match(input logic [5:0] cfg, input bit cur_bit, input bit prv);
    bit m;
    case (trig_val_e'(cfg[5:3]))
        LOGIC0:    m = (cur_bit == 1'b0);
        LOGIC1:    m = (cur_bit == 1'b1);
        RISE:      m = (prv == 1'b0 && cur_bit == 1'b1);
        FALL:      m = (prv == 1'b1 && cur_bit == 1'b0);
        ANY_EDGE:  m = (prv != cur_bit);
        NO_CHANGE: m = (prv == cur_bit);
        default:   m = 1'b1;
    endcase
    if (trig_op_e'(cfg[2:0]) == OP_NE) begin
        m = !m;
    end
    return m;
endfunction

// first logged sample in [from, upto) that fires, or -1
function automatic int find_trigger(input int from, input int upto, input logic [5:0] cfgs [8],
                                    input logic [1:0] mode);
    logic [7:0] m;
    bit         h;
    for (int k = from; k < upto; k++) begin
        for (int c = 0; c < 8; c++) begin
            m[c] = chan_match(cfgs[c], smp_log[k][c], smp_log[k - 1][c]);
        end
        case (global_mode_e'(mode))
            GLOBAL_AND:  h = (m == 8'hff);
            GLOBAL_OR:   h = (m != 8'h00);
            GLOBAL_NAND: h = (m != 8'hff);
            default:     h = (m == 8'h00);
        endcase
        if (h) begin
            return k;
        end
    end
    return -1;
endfunction

//--- testbench/tb_logic_analyzer.sv
`timescale 1ns/100ps

module tb_logic_analyzer import la_pkg::*; ();

    localparam int chan_num       = 8;
    localparam int wave_aw        = 12;   // 4096 samples in 1024 words
    localparam int timeout_cycles = 6 * (4096 + 2000);

    typedef struct packed {
        logic [bus_id_w-1:0] id;
        logic [7:0]          len;
        logic [1:0]          resp;
        logic                chk;   // compare r_data with exp_data
    } rd_ctx_t;

    logic                clk, rstn;
    logic [chan_num-1:0] digital_in;
    logic [bus_id_w-1:0] aw_id, b_id, ar_id, r_id;
    logic [31:0]         aw_addr, ar_addr, w_data, r_data;
    logic [7:0]          aw_len, ar_len;
    logic [1:0]          aw_burst, ar_burst, b_resp, r_resp;
    logic [3:0]          w_strb;
    logic                aw_valid, aw_ready, w_last, w_valid, w_ready, b_valid, b_ready;
    logic                ar_valid, ar_ready, r_last, r_valid, r_ready;

    logic [31:0]         lfsr = 32'h91fa_e769;
    int                  cyc = 0;
    int                  wr_idx, rd_beat;
    bit                  rd_done, held_valid;
    logic [31:0]         held_data;
    logic [bus_id_w-1:0] next_id;
    rd_ctx_t             cur;
    logic [31:0]         wr_buf [256];
    logic [31:0]         rd_buf [256];
    logic [31:0]         exp_data [$];
    logic [7:0]          smp_log [65536];   // sample driven in each cycle
    logic [5:0]          cfg_set [8];

    logic_analyzer_top #(.chan_num(chan_num), .wave_addr_width(wave_aw)) DUT (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] got);
        abort_run($sformatf("FAILED at time %0t: %s expected 0x%08h got 0x%08h",
                            $time, sig, exp, got));
    endtask

    `include "la_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc == timeout_cycles) begin
            abort_run("timeout: the run did not finish within the cycle limit");
        end
    end

    // random sample 1 ns after each edge
    initial begin
        digital_in = '0;
        smp_log[0] = '0;
        forever begin
            next_cycle();
            digital_in   = rand_bits(chan_num);
            smp_log[cyc] = digital_in;
        end
    end

    // read beats checked at the falling edge, where bus signals are stable
    always @(negedge clk) begin
        if (held_valid) begin
            assert (r_valid) else abort_run("r_valid dropped while the master was stalling");
            assert (r_data == held_data) else value_error("r_data held", held_data, r_data);
        end
        held_valid = r_valid && !r_ready;
        held_data  = r_data;
        if (r_valid && r_ready) begin
            assert (r_id == cur.id) else value_error("r_id", 32'(cur.id), 32'(r_id));
            assert (r_resp == cur.resp) else value_error("r_resp", 32'(cur.resp), 32'(r_resp));
            assert (r_last == (rd_beat == int'(cur.len)))
                else value_error("r_last", 32'(rd_beat == int'(cur.len)), 32'(r_last));
            if (cur.chk) begin
                assert (exp_data.size() > 0) else abort_run("read beat with no word expected");
                assert (r_data == exp_data[0]) else value_error("r_data", exp_data[0], r_data);
                void'(exp_data.pop_front());
            end
            rd_buf[rd_beat % 256] = r_data;
            rd_beat++;
            rd_done = r_last;
        end
    end

    task automatic load_config(input logic [1:0] mode);
        logic [1:0] resp;
        for (int i = 0; i < 8; i++) begin
            wr_buf[i] = {26'h3ff_ffff, cfg_set[i]};   // upper bits must be dropped
        end
        bus_write(REG_CHAN_BASE, BURST_INCR, 8, 4'hf, resp);
        assert (resp == RESP_OKAY) else value_error("b_resp", 32'(RESP_OKAY), 32'(resp));
        write_reg(REG_MODE, 32'(mode));
    endtask

    task automatic wait_done(output bit saw_busy);
        bit fin;
        saw_busy = 1'b0;
        fin      = 1'b0;
        while (!fin) begin
            bus_read(REG_CTRL, 0, BURST_INCR, 1'b0, 1'b0);
            saw_busy |= rd_buf[0][CTRL_BUSY_BIT];
            fin       = rd_buf[0][CTRL_DONE_BIT];
        end
        assert (saw_busy) else abort_run("done was read without busy seen high before it");
    endtask

    // 1024 words from the log, oldest sample in the low byte
    task automatic check_capture(input int start, input bit stall);
        int b;
        for (int blk = 0; blk < 4; blk++) begin
            for (int w = 0; w < 256; w++) begin
                b = start + 4 * (blk * 256 + w);
                exp_data.push_back({smp_log[b + 3], smp_log[b + 2], smp_log[b + 1], smp_log[b]});
            end
            bus_read(WAVE_BASE + 32'(blk * 256), 255, BURST_INCR, 1'b1, stall);
        end
    endtask

    task automatic triggered_run(input logic [1:0] mode, output int trig);
        int arm_idx;
        bit saw_busy;
        load_config(mode);
        write_reg(REG_CTRL, 32'h1);
        arm_idx = wr_idx;
        wait_done(saw_busy);
        trig = find_trigger(arm_idx, cyc - 1, cfg_set, mode);
        assert (trig >= 0) else abort_run("capture finished but the reference saw no trigger");
        check_capture(trig, 1'b0);
    endtask

    initial begin
        int         trig;
        bit         saw_busy;
        logic [1:0] resp;
        rstn     = 1'b0;
        next_id  = '0;
        aw_id    = '0;
        aw_addr  = '0;
        aw_len   = '0;
        aw_burst = '0;
        aw_valid = 1'b0;
        w_data   = '0;
        w_strb   = '0;
        w_last   = 1'b0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar_id    = '0;
        ar_addr  = '0;
        ar_len   = '0;
        ar_burst = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        repeat (3) next_cycle();

        // register access
        read_expect(REG_CTRL, 32'h0);
        read_expect(REG_MODE, 32'h0);
        for (int i = 0; i < 8; i++) begin
            exp_data.push_back(32'h10);
        end
        bus_read(REG_CHAN_BASE, 7, BURST_INCR, 1'b1, 1'b0);
        for (int i = 0; i < 8; i++) begin
            cfg_set[i] = 6'((i << 3) | (i % 6));
        end
        load_config(GLOBAL_NAND);
        read_expect(REG_MODE, 32'(GLOBAL_NAND));
        for (int i = 0; i < 8; i++) begin
            exp_data.push_back(32'(cfg_set[i]));
        end
        bus_read(REG_CHAN_BASE, 7, BURST_INCR, 1'b1, 1'b0);
        wr_buf[0] = 32'h3;
        bus_write(REG_MODE, BURST_INCR, 1, 4'b1110, resp);   // low byte strobe off
        assert (resp == RESP_OKAY) else value_error("b_resp", 32'(RESP_OKAY), 32'(resp));
        read_expect(REG_MODE, 32'(GLOBAL_NAND));
        read_expect(32'h0000_0020, 32'hffff_ffff);

        // error responses
        wr_buf[0] = 32'h1234_5678;
        bus_write(WAVE_BASE + 32'h5, BURST_INCR, 1, 4'hf, resp);
        assert (resp == RESP_SLVERR) else value_error("b_resp", 32'(RESP_SLVERR), 32'(resp));
        wr_buf[0] = 32'h3;
        wr_buf[1] = 32'h3;
        bus_write(REG_MODE, BURST_WRAP, 2, 4'hf, resp);
        assert (resp == RESP_SLVERR) else value_error("b_resp", 32'(RESP_SLVERR), 32'(resp));
        read_expect(REG_MODE, 32'(GLOBAL_NAND));
        bus_read(REG_CHAN_BASE, 3, BURST_WRAP, 1'b0, 1'b0);

        // forced capture, no channel can match
        for (int i = 0; i < 8; i++) begin
            cfg_set[i] = {DONT_CARE, OP_NE};
        end
        load_config(GLOBAL_AND);
        write_reg(REG_CTRL, 32'h1);
        wr_buf[0] = 32'h0000_0101;
        bus_write(REG_CTRL, BURST_INCR, 1, 4'b0010, resp);
        trig = wr_idx;
        wait_done(saw_busy);
        check_capture(trig, 1'b0);

        // rise on channel 2 under OR
        cfg_set[2] = {RISE, OP_EQ};
        triggered_run(GLOBAL_OR, trig);
        read_expect(REG_CTRL, 32'h0100_0000);   // arm cleared, done held

        // level and edge mix under NAND, then NOR
        cfg_set = '{{LOGIC1, OP_EQ}, {NO_CHANGE, OP_EQ}, {FALL, OP_EQ}, {LOGIC1, OP_NE},
                    {LOGIC0, OP_GT}, {DONT_CARE, OP_EQ}, {DONT_CARE, OP_EQ}, {DONT_CARE, OP_EQ}};
        triggered_run(GLOBAL_NAND, trig);
        for (int i = 3; i < 8; i++) begin
            cfg_set[i] = {DONT_CARE, OP_NE};
        end
        triggered_run(GLOBAL_NOR, trig);

        // same capture again with r_ready stalls
        check_capture(trig, 1'b1);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
